// ==== flist.f ====
+incdir+src
src/morse_pkg.sv
src/key_sequencer.sv
src/morse_table.sv
src/code_accumulator.sv
src/morse_decoder_top.sv
test/morse_decoder_props.sv
test/morse_decoder_tb.sv

// ==== src/code_accumulator.sv ====
`timescale 1ns/1ps
`include "morse_macros.svh"

module code_accumulator import morse_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  element_t    element,
    input  ascii_t      lookup_char,
    input  logic        lookup_is_char,
    input  logic        lookup_is_prefix,
    output morse_code_t lookup_code,
    output ascii_t      sout
);

    morse_code_t code;
    morse_code_t candidate;
    logic        is_mark;
    logic        code_empty;

    ////////////////////////////////////////////////////////////
    // table address
    ////////////////////////////////////////////////////////////

    assign is_mark    = (element == elem_dot) || (element == elem_dash);
    assign code_empty = (code.fields.len == '0);

    // held code with the current element shifted in
    always_comb begin
        candidate.fields.len     = code.fields.len + 1'b1;
        candidate.fields.pattern = {code.fields.pattern[`MORSE_MAX_LEN-2:0],
                                    element == elem_dash};
    end

    // one table answers both the extension test and the final lookup
    assign lookup_code = is_mark ? candidate : code;

    ////////////////////////////////////////////////////////////
    // code and output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            code <= '0;
        end else begin
            case (element)
                elem_dot, elem_dash: begin
                    // off the tree, start over
                    if (lookup_is_prefix) begin
                        code <= candidate;
                    end else begin
                        code <= '0;
                    end
                end
                elem_char_gap, elem_word_gap: begin
                    code <= '0;
                end
                default: begin
                    code <= code;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sout <= 8'h00;
        end else begin
            sout <= `NO_CHAR;
            // later gap cycles see an empty code and stay idle
            if (!code_empty && lookup_is_char) begin
                if (element == elem_char_gap) begin
                    sout <= lookup_char;
                end else if (element == elem_word_gap) begin
                    // pending character is dropped for the space
                    sout <= `ASCII_SPACE;
                end
            end
        end
    end

endmodule

// ==== src/key_sequencer.sv ====
`timescale 1ns/1ps
`include "morse_macros.svh"

module key_sequencer import morse_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     dot_key,
    input  logic     dash_key,
    input  logic     char_gap_key,
    input  logic     word_gap_key,
    output element_t element
);

    localparam int GAP_CNT_W = $clog2(`WORD_GAP_CYCLES);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_dot  = 2'd1;
    localparam logic [1:0] st_dash = 2'd2;
    localparam logic [1:0] st_gap  = 2'd3;

    logic [1:0]           state;
    logic [1:0]           state_nxt;
    logic [GAP_CNT_W-1:0] gap_cnt;
    logic [GAP_CNT_W-1:0] gap_cnt_nxt;
    logic                 word_gap;
    logic                 word_gap_nxt;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt    = state;
        gap_cnt_nxt  = gap_cnt;
        word_gap_nxt = word_gap;
        case (state)
            st_idle: begin
                // keys only looked at here, dot wins
                if (dot_key) begin
                    state_nxt = st_dot;
                end else if (dash_key) begin
                    state_nxt = st_dash;
                end else if (char_gap_key) begin
                    state_nxt    = st_gap;
                    word_gap_nxt = 1'b0;
                    gap_cnt_nxt  = GAP_CNT_W'(`CHAR_GAP_CYCLES - 1);
                end else if (word_gap_key) begin
                    state_nxt    = st_gap;
                    word_gap_nxt = 1'b1;
                    gap_cnt_nxt  = GAP_CNT_W'(`WORD_GAP_CYCLES - 1);
                end
            end
            st_dot, st_dash: begin
                state_nxt = st_idle;
            end
            st_gap: begin
                if (gap_cnt == '0) begin
                    state_nxt = st_idle;
                end else begin
                    gap_cnt_nxt = gap_cnt - 1'b1;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= st_idle;
            gap_cnt  <= '0;
            word_gap <= 1'b0;
        end else begin
            state    <= state_nxt;
            gap_cnt  <= gap_cnt_nxt;
            word_gap <= word_gap_nxt;
        end
    end

    // element decode from state
    always_comb begin
        case (state)
            st_dot:  element = elem_dot;
            st_dash: element = elem_dash;
            st_gap:  element = word_gap ? elem_word_gap : elem_char_gap;
            default: element = elem_none;
        endcase
    end

endmodule

// ==== src/morse_decoder_top.sv ====
`timescale 1ns/1ps

module morse_decoder_top import morse_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   dot_key,
    input  logic   dash_key,
    input  logic   char_gap_key,
    input  logic   word_gap_key,
    output ascii_t sout
);

    element_t    element;
    morse_code_t lookup_code;
    ascii_t      lookup_char;
    logic        lookup_is_char;
    logic        lookup_is_prefix;

    ////////////////////////////////////////////////////////////
    // key inputs to element stream
    ////////////////////////////////////////////////////////////

    key_sequencer key_sequencer_inst (
        .clk          (clk),
        .rst          (rst),
        .dot_key      (dot_key),
        .dash_key     (dash_key),
        .char_gap_key (char_gap_key),
        .word_gap_key (word_gap_key),
        .element      (element)
    );

    // code build and output byte
    code_accumulator code_accumulator_inst (
        .clk              (clk),
        .rst              (rst),
        .element          (element),
        .lookup_char      (lookup_char),
        .lookup_is_char   (lookup_is_char),
        .lookup_is_prefix (lookup_is_prefix),
        .lookup_code      (lookup_code),
        .sout             (sout)
    );

    morse_table morse_table_inst (
        .lookup_code      (lookup_code),
        .lookup_char      (lookup_char),
        .lookup_is_char   (lookup_is_char),
        .lookup_is_prefix (lookup_is_prefix)
    );

endmodule

// ==== src/morse_macros.svh ====
`ifndef MORSE_MACROS_SVH
`define MORSE_MACROS_SVH

////////////////////////////////////////////////////////////
// code word geometry
////////////////////////////////////////////////////////////

// longest letter or digit code
`define MORSE_MAX_LEN 5
// length field, wide enough for one element past the limit
`define MORSE_LEN_W 3

// gap lengths in clock cycles
`define CHAR_GAP_CYCLES 3
`define WORD_GAP_CYCLES 7

////////////////////////////////////////////////////////////
// output bytes
////////////////////////////////////////////////////////////

`define NO_CHAR 8'hff
`define ASCII_SPACE 8'h20

`endif

// ==== src/morse_pkg.sv ====
`include "morse_macros.svh"

package morse_pkg;

    // element currently presented by the key sequencer
    typedef enum logic [2:0] {
        elem_none     = 3'd0,
        elem_dot      = 3'd1,
        elem_dash     = 3'd2,
        elem_char_gap = 3'd3,
        elem_word_gap = 3'd4
    } element_t;

    ////////////////////////////////////////////////////////////
    // code word
    ////////////////////////////////////////////////////////////

    // pattern bits: dash is 1, newest element in the lsb
    // raw view is what the table decodes
    typedef union packed {
        struct packed {
            logic [`MORSE_LEN_W-1:0]   len;
            logic [`MORSE_MAX_LEN-1:0] pattern;
        } fields;
        logic [`MORSE_LEN_W+`MORSE_MAX_LEN-1:0] raw;
    } morse_code_t;

    // decoded output character
    typedef logic [7:0] ascii_t;

endpackage

// ==== src/morse_table.sv ====
`timescale 1ns/1ps
`include "morse_macros.svh"

module morse_table import morse_pkg::*; (
    input  morse_code_t lookup_code,
    output ascii_t      lookup_char,
    output logic        lookup_is_char,
    output logic        lookup_is_prefix
);

    // every listed code is on the tree, so prefix defaults true
    always_comb begin
        lookup_char      = `NO_CHAR;
        lookup_is_char   = 1'b1;
        lookup_is_prefix = 1'b1;
        case (lookup_code.raw)
            ////////////////////////////////////////////////////////////
            // one and two elements
            ////////////////////////////////////////////////////////////
            {3'd1, 5'b00000}: lookup_char = "e";
            {3'd1, 5'b00001}: lookup_char = "t";
            {3'd2, 5'b00000}: lookup_char = "i";
            {3'd2, 5'b00001}: lookup_char = "a";
            {3'd2, 5'b00010}: lookup_char = "n";
            {3'd2, 5'b00011}: lookup_char = "m";
            // three elements
            {3'd3, 5'b00000}: lookup_char = "s";
            {3'd3, 5'b00001}: lookup_char = "u";
            {3'd3, 5'b00010}: lookup_char = "r";
            {3'd3, 5'b00011}: lookup_char = "w";
            {3'd3, 5'b00100}: lookup_char = "d";
            {3'd3, 5'b00101}: lookup_char = "k";
            {3'd3, 5'b00110}: lookup_char = "g";
            {3'd3, 5'b00111}: lookup_char = "o";
            ////////////////////////////////////////////////////////////
            // four elements
            ////////////////////////////////////////////////////////////
            {3'd4, 5'b00000}: lookup_char = "h";
            {3'd4, 5'b00001}: lookup_char = "v";
            {3'd4, 5'b00010}: lookup_char = "f";
            {3'd4, 5'b00100}: lookup_char = "l";
            {3'd4, 5'b00110}: lookup_char = "p";
            {3'd4, 5'b00111}: lookup_char = "j";
            {3'd4, 5'b01000}: lookup_char = "b";
            {3'd4, 5'b01001}: lookup_char = "x";
            {3'd4, 5'b01010}: lookup_char = "c";
            {3'd4, 5'b01011}: lookup_char = "y";
            {3'd4, 5'b01100}: lookup_char = "z";
            {3'd4, 5'b01101}: lookup_char = "q";
            // digit prefixes with no letter of their own
            {3'd4, 5'b00011}: lookup_is_char = 1'b0;
            {3'd4, 5'b01110}: lookup_is_char = 1'b0;
            {3'd4, 5'b01111}: lookup_is_char = 1'b0;
            ////////////////////////////////////////////////////////////
            // five elements, digits only
            ////////////////////////////////////////////////////////////
            {3'd5, 5'b11111}: lookup_char = "0";
            {3'd5, 5'b01111}: lookup_char = "1";
            {3'd5, 5'b00111}: lookup_char = "2";
            {3'd5, 5'b00011}: lookup_char = "3";
            {3'd5, 5'b00001}: lookup_char = "4";
            {3'd5, 5'b00000}: lookup_char = "5";
            {3'd5, 5'b10000}: lookup_char = "6";
            {3'd5, 5'b11000}: lookup_char = "7";
            {3'd5, 5'b11100}: lookup_char = "8";
            {3'd5, 5'b11110}: lookup_char = "9";
            // empty code, dead branches, over-long codes
            default: begin
                lookup_is_char   = 1'b0;
                lookup_is_prefix = 1'b0;
            end
        endcase
    end

endmodule

// ==== test/morse_decoder_props.sv ====
`timescale 1ns/1ps
`include "morse_macros.svh"

module morse_decoder_props import morse_pkg::*; (
    input logic        clk,
    input logic        rst,
    input morse_code_t code,
    input ascii_t      sout
);

    // idle, space, digit or lower-case letter
    function automatic logic legal_byte(ascii_t b);
        return (b == `NO_CHAR) || (b == `ASCII_SPACE) ||
               (b >= "0" && b <= "9") || (b >= "a" && b <= "z");
    endfunction

    ////////////////////////////////////////////////////////////
    // code register
    ////////////////////////////////////////////////////////////

    len_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        code.fields.len <= `MORSE_MAX_LEN
    ) else $error("code length beyond the longest Morse code");

    ////////////////////////////////////////////////////////////
    // output byte
    ////////////////////////////////////////////////////////////

    // first clock after release still shows the reset value
    sout_legal: assert property (
        @(posedge clk) disable iff (!rst)
        $past(rst) |-> legal_byte(sout)
    ) else $error("sout holds a byte outside the decoded set");

    sout_one_cycle: assert property (
        @(posedge clk) disable iff (!rst)
        ($past(rst) && sout != `NO_CHAR) |=> sout == `NO_CHAR
    ) else $error("decoded byte held on sout for more than one cycle");

endmodule

bind code_accumulator morse_decoder_props morse_decoder_props_inst (
    .clk  (clk),
    .rst  (rst),
    .code (code),
    .sout (sout)
);

// ==== test/morse_decoder_tb.sv ====
`timescale 1ns/1ps
`include "morse_macros.svh"

module morse_decoder_tb import morse_pkg::*; ();

    localparam int RANDOM_STEPS = 800;
    localparam int DRAIN_LIMIT  = 200;

    logic   clk;
    logic   rst;
    logic   dot_key;
    logic   dash_key;
    logic   char_gap_key;
    logic   word_gap_key;
    ascii_t sout;

    integer seed;
    string  test_name;
    string  model_code;
    ascii_t expected_q[$];
    logic   monitor_en;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    morse_decoder_top morse_decoder_top_inst (
        .clk          (clk),
        .rst          (rst),
        .dot_key      (dot_key),
        .dash_key     (dash_key),
        .char_gap_key (char_gap_key),
        .word_gap_key (word_gap_key),
        .sout         (sout)
    );

    ////////////////////////////////////////////////////////////
    // reference Morse table
    ////////////////////////////////////////////////////////////

    // a to z, then 0 to 9
    function automatic string code_of(int idx);
        case (idx)
            0:  return ".-";
            1:  return "-...";
            2:  return "-.-.";
            3:  return "-..";
            4:  return ".";
            5:  return "..-.";
            6:  return "--.";
            7:  return "....";
            8:  return "..";
            9:  return ".---";
            10: return "-.-";
            11: return ".-..";
            12: return "--";
            13: return "-.";
            14: return "---";
            15: return ".--.";
            16: return "--.-";
            17: return ".-.";
            18: return "...";
            19: return "-";
            20: return "..-";
            21: return "...-";
            22: return ".--";
            23: return "-..-";
            24: return "-.--";
            25: return "--..";
            26: return "-----";
            27: return ".----";
            28: return "..---";
            29: return "...--";
            30: return "....-";
            31: return ".....";
            32: return "-....";
            33: return "--...";
            34: return "---..";
            35: return "----.";
            default: return "";
        endcase
    endfunction

    function automatic ascii_t char_of(int idx);
        if (idx < 26) begin
            return ascii_t'("a" + idx);
        end else begin
            return ascii_t'("0" + idx - 26);
        end
    endfunction

    // true for a full code or any proper prefix of one
    function automatic bit on_tree(string s);
        string c;
        for (int i = 0; i < 36; i++) begin
            c = code_of(i);
            if (c.len() >= s.len() && c.substr(0, s.len() - 1) == s) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int find_char(string s);
        for (int i = 0; i < 36; i++) begin
            if (code_of(i) == s) begin
                return i;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////
    // model, stimulus and checks
    ////////////////////////////////////////////////////////////

    // keys as {dot, dash, char gap, word gap}, dot has priority
    task automatic model_key(logic [3:0] keys);
        string cand;
        int    idx;
        if (keys[3] || keys[2]) begin
            if (keys[3]) begin
                cand = {model_code, "."};
            end else begin
                cand = {model_code, "-"};
            end
            if (on_tree(cand)) begin
                model_code = cand;
            end else begin
                model_code = "";
            end
        end else if (keys[1] || keys[0]) begin
            idx = find_char(model_code);
            if (model_code.len() != 0 && idx >= 0) begin
                expected_q.push_back(keys[1] ? char_of(idx) : `ASCII_SPACE);
            end
            model_code = "";
        end
    endtask

    // one cycle of keys, then idle long enough for any gap to finish
    task automatic key_step(logic [3:0] keys);
        {dot_key, dash_key, char_gap_key, word_gap_key} = keys;
        model_key(keys);
        @(negedge clk);
        {dot_key, dash_key, char_gap_key, word_gap_key} = 4'b0000;
        repeat (8) @(negedge clk);
    endtask

    task automatic key_code(string s);
        for (int i = 0; i < s.len(); i++) begin
            key_step((s[i] == ".") ? 4'b1000 : 4'b0100);
        end
    endtask

    // weighted main key plus random lower-priority keys
    function automatic logic [3:0] random_keys();
        logic [31:0] r;
        logic [3:0]  main;
        logic [3:0]  lower;
        r = $random(seed);
        case (r[2:0])
            3'd0, 3'd1, 3'd2: main = 4'b1000;
            3'd3, 3'd4:       main = 4'b0100;
            3'd5:             main = 4'b0010;
            3'd6:             main = 4'b0001;
            default:          main = 4'b0000;
        endcase
        lower = (main == 4'b0000) ? 4'b0000 : main - 4'b0001;
        return main | (r[7:4] & lower);
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_char(string name, ascii_t expected, ascii_t actual);
        if (expected !== actual) begin
            $display("** Error [%s] expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    always @(negedge clk) begin
        if (monitor_en && sout !== `NO_CHAR) begin
            if (expected_q.size() == 0) begin
                $display("%s: sout showed %h while no character was expected",
                         test_name, sout);
                abort_run();
            end else begin
                check_char(test_name, expected_q.pop_front(), sout);
            end
        end
    end

    initial begin
        int wait_cycles;
        seed         = 32'h36e8034b;
        rst          = 1'b0;
        dot_key      = 1'b0;
        dash_key     = 1'b0;
        char_gap_key = 1'b0;
        word_gap_key = 1'b0;
        monitor_en   = 1'b0;
        model_code   = "";
        test_name    = "reset";
        repeat (8) begin
            @(negedge clk);
            check_char(test_name, 8'h00, sout);
        end
        rst = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_char(test_name, `NO_CHAR, sout);
        end
        monitor_en = 1'b1;

        test_name = "letters_digits";
        for (int idx = 0; idx < 36; idx++) begin
            key_code(code_of(idx));
            key_step(4'b0010);
        end

        test_name = "word_gap";
        key_code("-...");
        key_step(4'b0001);

        // nothing expected from these
        test_name = "empty_and_prefix";
        key_step(4'b0010);
        key_step(4'b0001);
        key_code("..--");
        key_step(4'b0010);
        key_code("----");
        key_step(4'b0001);

        test_name = "dead_branch";
        key_code("-...");
        key_step(4'b0100);
        key_code(".-");
        key_step(4'b0010);
        key_code(".....");
        key_step(4'b1000);
        key_code("-");
        key_step(4'b0010);
        key_code(".-.-");
        key_code("--");
        key_step(4'b0010);

        test_name = "multi_key";
        key_step(4'b1111);
        key_step(4'b0111);
        key_step(4'b0011);

        test_name = "random";
        repeat (RANDOM_STEPS) key_step(random_keys());

        test_name   = "drain";
        wait_cycles = 0;
        while (expected_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("drain: %0d expected characters never appeared on sout",
                     expected_q.size());
            abort_run();
        end else begin
            repeat (10) @(negedge clk);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
